//--- Bender.yml
package:
  name: aa_bridge

sources:
  - files:
      - common/aa_pkg.sv
      - aa_regfile/aa_regfile.sv
      - ls_bridge/ls_bridge.sv
      - ss_bridge/ss_bridge.sv
      - rtl/aa_stream_tx.sv
      - rtl/aa_bridge.sv
  - target: test
    files:
      - tests/aa_bridge_asserts.sv
      - tests/aa_bridge_tb.sv

//--- aa_regfile/aa_regfile.sv
// interrupt enable and status bits plus the eight word mailbox
// offset 8 and up in the control page alias the two control words
// the local port wins any same-register conflict
`timescale 1ns/1ps

module aa_regfile
  import aa_pkg::*;
(
  input  logic                 axis_clk,
  input  logic                 axis_rst_n,
  input  aa_reg_wr_t           loc_wr,
  input  aa_reg_wr_t           rem_wr,
  input  logic [aa_idx_w-1:0]  loc_rd_idx,
  input  aa_region_e           loc_rd_region,
  output logic [aa_data_w-1:0] loc_rd_data,
  input  logic [aa_idx_w-1:0]  rem_rd_idx,
  input  aa_region_e           rem_rd_region,
  output logic [aa_data_w-1:0] rem_rd_data,
  output logic                 mb_irq
);

  logic                 intr_enable, intr_status;
  logic [aa_data_w-1:0] mbox [aa_mbox_depth];
  logic                 loc_mbox_we, rem_mbox_we;
  logic                 loc_en_we, rem_en_we, loc_clr, rem_set;

  function automatic logic [aa_data_w-1:0] byte_merge(input logic [aa_data_w-1:0] old,
                                                      input logic [aa_data_w-1:0] wdata,
                                                      input logic [aa_strb_w-1:0] wstrb);
    logic [aa_data_w-1:0] res;
    res = old;
    for (int b = 0; b < aa_strb_w; b++) begin
      if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [aa_data_w-1:0] rd_word(input aa_region_e region,
                                                   input logic sel_status,
                                                   input logic enable, input logic status,
                                                   input logic [aa_data_w-1:0] mbox_word);
    case (region)
      region_reg:  return {{(aa_data_w-1){1'b0}}, sel_status ? status : enable};
      region_mbox: return mbox_word;
      default:     return '0;
    endcase
  endfunction

  // --------------------
  // write decode
  // --------------------
  assign loc_mbox_we = loc_wr.valid && (loc_wr.region == region_mbox);
  // remote write to the word the local side writes is lost
  assign rem_mbox_we = rem_wr.valid && (rem_wr.region == region_mbox) &&
                       !(loc_mbox_we && (loc_wr.idx == rem_wr.idx));
  assign loc_en_we   = loc_wr.valid && (loc_wr.region == region_reg) &&
                       !loc_wr.idx[0] && loc_wr.wstrb[0];
  assign rem_en_we   = rem_wr.valid && (rem_wr.region == region_reg) &&
                       !rem_wr.idx[0] && rem_wr.wstrb[0];
  // status is write one to clear from the local side only
  assign loc_clr     = loc_wr.valid && (loc_wr.region == region_reg) &&
                       loc_wr.idx[0] && loc_wr.wstrb[0] && loc_wr.wdata[0];
  assign rem_set     = rem_mbox_we && (|rem_wr.wstrb);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (loc_en_we) intr_enable <= loc_wr.wdata[0];
      else if (rem_en_we) intr_enable <= rem_wr.wdata[0];
      if (loc_clr) intr_status <= 1'b0;
      else if (rem_set) intr_status <= 1'b1;
    end
  end

  // mailbox words keep no reset value
  always_ff @(posedge axis_clk) begin
    if (loc_mbox_we) mbox[loc_wr.idx] <= byte_merge(mbox[loc_wr.idx], loc_wr.wdata, loc_wr.wstrb);
    if (rem_mbox_we) mbox[rem_wr.idx] <= byte_merge(mbox[rem_wr.idx], rem_wr.wdata, rem_wr.wstrb);
  end

  // --------------------
  // read ports
  // --------------------
  assign loc_rd_data = rd_word(loc_rd_region, loc_rd_idx[0], intr_enable, intr_status,
                               mbox[loc_rd_idx]);
  assign rem_rd_data = rd_word(rem_rd_region, rem_rd_idx[0], intr_enable, intr_status,
                               mbox[rem_rd_idx]);

  assign mb_irq = intr_status && intr_enable;

endmodule

//--- common/aa_pkg.sv
// shared types and constants for the AXI-Lite to stream bridge
// one clock domain only and no FIFO on either side
// the register block decodes only address bits 4:2 inside a page

package aa_pkg;

  // --------------------
  // widths and decode
  // --------------------
  localparam int aa_data_w     = 32;
  localparam int aa_strb_w     = aa_data_w / 8;
  localparam int aa_ls_addr_w  = 15;
  localparam int aa_hdr_addr_w = 28;
  localparam int aa_mbox_depth = 8;
  localparam int aa_idx_w      = $clog2(aa_mbox_depth);

  // local bits 14:12 select the block and bits 11:8 give the page
  localparam logic [2:0]  aa_block_sel   = 3'b010;
  localparam logic [3:0]  aa_reg_page    = 4'h1;
  localparam logic [3:0]  aa_mbox_page   = 4'h0;
  // header bits 27:8 compare against this prefix plus the page
  localparam logic [19:0] aa_remote_base = 20'h00020;

  // tuser cycle type of a stream beat
  typedef enum logic [1:0] {
    cyc_axis     = 2'b00,
    cyc_write    = 2'b01,
    cyc_read_req = 2'b10,
    cyc_read_cpl = 2'b11
  } aa_cyc_e;

  typedef enum logic [1:0] {
    region_reg,
    region_mbox,
    region_remote
  } aa_region_e;

  typedef enum logic [3:0] {
    ls_idle, ls_decode, ls_wr_hdr, ls_wr_data, ls_rd_req,
    ls_rd_wait, ls_wr_done, ls_rd_done, ls_mbox_done
  } ls_state_e;

  typedef enum logic [1:0] {
    ss_idle, ss_wr_data, ss_wr_apply, ss_rd_cpl
  } ss_state_e;

  typedef struct packed {
    logic [aa_data_w-1:0] tdata;
    logic [aa_strb_w-1:0] tstrb;
    aa_cyc_e              tuser;
  } aa_beat_t;

  // in the control page idx 0 is intr_enable and idx 1 is intr_status
  typedef struct packed {
    logic                 valid;
    aa_region_e           region;
    logic [aa_idx_w-1:0]  idx;
    logic [aa_strb_w-1:0] wstrb;
    logic [aa_data_w-1:0] wdata;
  } aa_reg_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [aa_data_w-1:0] data;
  } aa_cpl_t;

  function automatic aa_region_e aa_ls_region(input logic [aa_ls_addr_w-1:0] addr);
    if (addr[14:12] != aa_block_sel) return region_remote;
    if (addr[11:8] == aa_reg_page) return region_reg;
    if (addr[11:8] == aa_mbox_page) return region_mbox;
    return region_remote;
  endfunction

  function automatic aa_region_e aa_ss_region(input logic [aa_hdr_addr_w-1:0] addr);
    if (addr[27:8] == aa_remote_base + 20'(aa_reg_page)) return region_reg;
    if (addr[27:8] == aa_remote_base + 20'(aa_mbox_page)) return region_mbox;
    return region_remote;
  endfunction

endpackage

//--- ls_bridge/ls_bridge.sv
// AXI-Lite slave side of the bridge
// requests are taken only while cc_aa_enable is high
// one request at a time and a write needs AW and W valid together
`timescale 1ns/1ps

module ls_bridge
  import aa_pkg::*;
(
  input  logic                    axis_clk,
  input  logic                    axis_rst_n,
  output logic                    s_awready,
  input  logic                    s_awvalid,
  input  logic [aa_ls_addr_w-1:0] s_awaddr,
  output logic                    s_wready,
  input  logic                    s_wvalid,
  input  logic [aa_data_w-1:0]    s_wdata,
  input  logic [aa_strb_w-1:0]    s_wstrb,
  output logic                    s_arready,
  input  logic                    s_arvalid,
  input  logic [aa_ls_addr_w-1:0] s_araddr,
  output logic [aa_data_w-1:0]    s_rdata,
  output logic                    s_rvalid,
  input  logic                    s_rready,
  input  logic                    cc_aa_enable,
  output logic                    tx_req,
  output aa_beat_t                tx_beat,
  input  logic                    tx_grant,
  input  logic                    beat_done,
  output aa_reg_wr_t              loc_wr,
  output logic [aa_idx_w-1:0]     loc_rd_idx,
  output aa_region_e              loc_rd_region,
  input  logic [aa_data_w-1:0]    loc_rd_data,
  output logic                    cpl_wait,
  input  aa_cpl_t                 cpl
);

  ls_state_e                 state, state_nxt;
  logic                      r_is_wr;
  logic [aa_ls_addr_w-1:0]   r_addr;
  logic [aa_strb_w-1:0]      r_wstrb;
  logic [aa_data_w-1:0]      r_wdata;
  logic [aa_data_w-1:0]      r_cpl_data;
  logic [aa_hdr_addr_w-1:0]  hdr_addr;
  aa_region_e                region;
  logic                      start, tx_fire;

  assign region   = aa_ls_region(r_addr);
  assign hdr_addr = {{(aa_hdr_addr_w - aa_ls_addr_w){1'b0}}, r_addr};
  assign start    = (state == ls_idle) && cc_aa_enable && ((s_awvalid && s_wvalid) || s_arvalid);
  assign tx_fire  = tx_grant && beat_done;

  // --------------------
  // request FSM
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ls_idle:      if (start) state_nxt = ls_decode;
      ls_decode:
        if (r_is_wr) begin
          if (region == region_reg) state_nxt = ls_wr_done;
          else if (region == region_mbox) state_nxt = ls_mbox_done;
          else state_nxt = ls_wr_hdr;
        end else begin
          state_nxt = (region == region_remote) ? ls_rd_req : ls_rd_done;
        end
      ls_wr_hdr:    if (tx_fire) state_nxt = ls_wr_data;
      // a forwarded mailbox write was acknowledged before its beats
      ls_wr_data:
        if (tx_fire) state_nxt = (region == region_mbox) ? ls_idle : ls_wr_done;
      ls_rd_req:    if (tx_fire) state_nxt = ls_rd_wait;
      ls_rd_wait:   if (cpl.valid) state_nxt = ls_rd_done;
      ls_rd_done:   if (s_rready) state_nxt = ls_idle;
      ls_wr_done:   state_nxt = ls_idle;
      ls_mbox_done: state_nxt = ls_wr_hdr;
      default:      state_nxt = ls_idle;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state   <= ls_idle;
      r_is_wr <= 1'b0;
    end else begin
      state <= state_nxt;
      if (start) r_is_wr <= s_awvalid && s_wvalid;
    end
  end

  // request latches and remote read data
  always_ff @(posedge axis_clk) begin
    if (start) begin
      r_addr  <= (s_awvalid && s_wvalid) ? s_awaddr : s_araddr;
      r_wstrb <= s_wstrb;
      r_wdata <= s_wdata;
    end
    if (state == ls_rd_wait && cpl.valid) r_cpl_data <= cpl.data;
  end

  // --------------------
  // axi-lite outputs
  // --------------------
  assign s_awready = (state == ls_wr_done) || (state == ls_mbox_done);
  assign s_wready  = s_awready;
  assign s_arready = (state == ls_decode) && !r_is_wr;
  assign s_rvalid  = (state == ls_rd_done);
  assign s_rdata   = (region == region_remote) ? r_cpl_data : loc_rd_data;

  // local register write lands on the ready pulse
  assign loc_wr.valid  = s_awready && (region != region_remote);
  assign loc_wr.region = region;
  assign loc_wr.idx    = r_addr[aa_idx_w+1:2];
  assign loc_wr.wstrb  = r_wstrb;
  assign loc_wr.wdata  = r_wdata;

  assign loc_rd_idx    = r_addr[aa_idx_w+1:2];
  assign loc_rd_region = region;
  assign cpl_wait      = (state == ls_rd_wait);

  // --------------------
  // outgoing beats
  // --------------------
  assign tx_req = (state == ls_wr_hdr) || (state == ls_wr_data) || (state == ls_rd_req);

  always_comb begin
    // write header carries wstrb on top of the address
    tx_beat.tdata = {r_wstrb, hdr_addr};
    tx_beat.tstrb = r_wstrb;
    tx_beat.tuser = cyc_write;
    if (state == ls_wr_data) tx_beat.tdata = r_wdata;
    if (state == ls_rd_req) begin
      tx_beat.tdata = {{aa_strb_w{1'b0}}, hdr_addr};
      tx_beat.tstrb = '1;
      tx_beat.tuser = cyc_read_req;
    end
  end

endmodule

//--- rtl/aa_bridge.sv
// top of the bridge between local AXI-Lite and the remote stream link
// writes complete on an s_awready/s_wready pulse and there is no B channel
// a remote read outside the register block never gets a completion
`timescale 1ns/1ps

module aa_bridge
  import aa_pkg::*;
(
  input  logic                    axis_clk,
  input  logic                    axis_rst_n,
  // axi-lite slave
  output logic                    s_awready,
  input  logic                    s_awvalid,
  input  logic [aa_ls_addr_w-1:0] s_awaddr,
  output logic                    s_wready,
  input  logic                    s_wvalid,
  input  logic [aa_data_w-1:0]    s_wdata,
  input  logic [aa_strb_w-1:0]    s_wstrb,
  output logic                    s_arready,
  input  logic                    s_arvalid,
  input  logic [aa_ls_addr_w-1:0] s_araddr,
  output logic [aa_data_w-1:0]    s_rdata,
  output logic                    s_rvalid,
  input  logic                    s_rready,
  // stream in
  input  logic [aa_data_w-1:0]    as_aa_tdata,
  input  logic [aa_strb_w-1:0]    as_aa_tstrb,
  input  logic [1:0]              as_aa_tuser,
  input  logic                    as_aa_tvalid,
  output logic                    aa_as_tready,
  // stream out
  output logic [aa_data_w-1:0]    aa_as_tdata,
  output logic [aa_strb_w-1:0]    aa_as_tstrb,
  output logic [1:0]              aa_as_tuser,
  output logic                    aa_as_tvalid,
  input  logic                    as_aa_tready,
  input  logic                    cc_aa_enable,
  output logic                    mb_irq
);

  logic                 ls_req, ss_req, ls_grant, ss_grant, beat_done, cpl_wait;
  aa_beat_t             ls_beat, ss_beat;
  aa_reg_wr_t           loc_wr, rem_wr;
  aa_cpl_t              cpl;
  logic [aa_idx_w-1:0]  loc_rd_idx, rem_rd_idx;
  aa_region_e           loc_rd_region, rem_rd_region;
  logic [aa_data_w-1:0] loc_rd_data, rem_rd_data;

  ls_bridge ls_bridge_i (
    .axis_clk, .axis_rst_n,
    .s_awready, .s_awvalid, .s_awaddr, .s_wready, .s_wvalid, .s_wdata, .s_wstrb,
    .s_arready, .s_arvalid, .s_araddr, .s_rdata, .s_rvalid, .s_rready,
    .cc_aa_enable,
    .tx_req (ls_req), .tx_beat (ls_beat), .tx_grant (ls_grant), .beat_done,
    .loc_wr, .loc_rd_idx, .loc_rd_region, .loc_rd_data,
    .cpl_wait, .cpl
  );

  ss_bridge ss_bridge_i (
    .axis_clk, .axis_rst_n,
    .as_aa_tdata, .as_aa_tstrb, .as_aa_tuser, .as_aa_tvalid, .aa_as_tready,
    .rem_wr, .rem_rd_idx, .rem_rd_region, .rem_rd_data,
    .tx_req (ss_req), .tx_beat (ss_beat), .tx_grant (ss_grant), .beat_done,
    .cpl_wait, .cpl
  );

  aa_stream_tx aa_stream_tx_i (
    .axis_clk, .axis_rst_n,
    .ls_req, .ls_beat, .ss_req, .ss_beat, .ls_grant, .ss_grant, .beat_done,
    .aa_as_tdata, .aa_as_tstrb, .aa_as_tuser, .aa_as_tvalid, .as_aa_tready
  );

  aa_regfile aa_regfile_i (
    .axis_clk, .axis_rst_n, .loc_wr, .rem_wr,
    .loc_rd_idx, .loc_rd_region, .loc_rd_data,
    .rem_rd_idx, .rem_rd_region, .rem_rd_data, .mb_irq
  );

endmodule

//--- rtl/aa_stream_tx.sv
// outgoing stream arbiter with the stream bridge ahead of the AXI-Lite side
// a requester keeps req high over its whole message and holds its beat
`timescale 1ns/1ps

module aa_stream_tx
  import aa_pkg::*;
(
  input  logic                 axis_clk,
  input  logic                 axis_rst_n,
  input  logic                 ls_req,
  input  aa_beat_t             ls_beat,
  input  logic                 ss_req,
  input  aa_beat_t             ss_beat,
  output logic                 ls_grant,
  output logic                 ss_grant,
  output logic                 beat_done,
  output logic [aa_data_w-1:0] aa_as_tdata,
  output logic [aa_strb_w-1:0] aa_as_tstrb,
  output logic [1:0]           aa_as_tuser,
  output logic                 aa_as_tvalid,
  input  logic                 as_aa_tready
);

  aa_beat_t out_beat;

  // owner is picked only while the link is free
  // and released once its requester drops req
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ls_grant <= 1'b0;
      ss_grant <= 1'b0;
    end else if (!ls_grant && !ss_grant) begin
      ss_grant <= ss_req;
      ls_grant <= ls_req && !ss_req;
    end else begin
      if (ls_grant && !ls_req) ls_grant <= 1'b0;
      if (ss_grant && !ss_req) ss_grant <= 1'b0;
    end
  end

  assign out_beat     = ss_grant ? ss_beat : ls_beat;
  assign aa_as_tvalid = (ls_grant && ls_req) || (ss_grant && ss_req);
  assign aa_as_tdata  = out_beat.tdata;
  assign aa_as_tstrb  = out_beat.tstrb;
  assign aa_as_tuser  = out_beat.tuser;
  // one pulse per transferred beat, qualified by grant in each bridge
  assign beat_done    = aa_as_tvalid && as_aa_tready;

endmodule

//--- ss_bridge/ss_bridge.sv
// stream slave side of the bridge
// writes outside the register block are consumed and dropped
// reads outside the block are consumed with no completion
// a completion beat is taken only while the AXI-Lite side waits for one
`timescale 1ns/1ps

module ss_bridge
  import aa_pkg::*;
(
  input  logic                 axis_clk,
  input  logic                 axis_rst_n,
  input  logic [aa_data_w-1:0] as_aa_tdata,
  input  logic [aa_strb_w-1:0] as_aa_tstrb,
  input  logic [1:0]           as_aa_tuser,
  input  logic                 as_aa_tvalid,
  output logic                 aa_as_tready,
  output aa_reg_wr_t           rem_wr,
  output logic [aa_idx_w-1:0]  rem_rd_idx,
  output aa_region_e           rem_rd_region,
  input  logic [aa_data_w-1:0] rem_rd_data,
  output logic                 tx_req,
  output aa_beat_t             tx_beat,
  input  logic                 tx_grant,
  input  logic                 beat_done,
  input  logic                 cpl_wait,
  output aa_cpl_t              cpl
);

  ss_state_e                state;
  logic [aa_hdr_addr_w-1:0] r_addr;
  logic [aa_strb_w-1:0]     r_wstrb;
  logic [aa_data_w-1:0]     r_wdata;
  aa_region_e               region;
  aa_region_e               hdr_region;
  logic                     hdr_fire, data_fire;

  assign region     = aa_ss_region(r_addr);
  assign hdr_region = aa_ss_region(as_aa_tdata[aa_hdr_addr_w-1:0]);

  // a completion is held off unless a local read is waiting
  assign aa_as_tready = (state == ss_wr_data) ||
                        ((state == ss_idle) && ((as_aa_tuser != cyc_read_cpl) || cpl_wait));
  assign hdr_fire  = (state == ss_idle) && as_aa_tvalid && aa_as_tready;
  assign data_fire = (state == ss_wr_data) && as_aa_tvalid;

  // --------------------
  // header FSM
  // --------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= ss_idle;
    end else begin
      case (state)
        ss_idle:
          if (hdr_fire) begin
            if (as_aa_tuser == cyc_write) state <= ss_wr_data;
            else if (as_aa_tuser == cyc_read_req && hdr_region != region_remote)
              state <= ss_rd_cpl;
          end
        ss_wr_data:  if (data_fire) state <= ss_wr_apply;
        ss_wr_apply: state <= ss_idle;
        ss_rd_cpl:   if (tx_grant && beat_done) state <= ss_idle;
        default:     state <= ss_idle;
      endcase
    end
  end

  // header and data capture
  always_ff @(posedge axis_clk) begin
    if (hdr_fire) begin
      r_addr  <= as_aa_tdata[aa_hdr_addr_w-1:0];
      r_wstrb <= as_aa_tdata[aa_data_w-1:aa_hdr_addr_w];
    end
    // bytes the data beat marks as null are not written
    if (data_fire) begin
      r_wdata <= as_aa_tdata;
      r_wstrb <= r_wstrb & as_aa_tstrb;
    end
  end

  // one write pulse in the cycle after the data beat
  assign rem_wr.valid  = (state == ss_wr_apply) && (region != region_remote);
  assign rem_wr.region = region;
  assign rem_wr.idx    = r_addr[aa_idx_w+1:2];
  assign rem_wr.wstrb  = r_wstrb;
  assign rem_wr.wdata  = r_wdata;

  assign rem_rd_idx    = r_addr[aa_idx_w+1:2];
  assign rem_rd_region = region;

  // --------------------
  // completion paths
  // --------------------
  assign tx_req        = (state == ss_rd_cpl);
  assign tx_beat.tdata = rem_rd_data;
  assign tx_beat.tstrb = '1;
  assign tx_beat.tuser = cyc_read_cpl;

  // incoming completion goes straight to the AXI-Lite side
  assign cpl.valid = hdr_fire && (as_aa_tuser == cyc_read_cpl);
  assign cpl.data  = as_aa_tdata;

endmodule

//--- tests/aa_bridge_asserts.sv
// handshake checks bound into aa_bridge
// checks are held off while axis_rst_n is low
// fail_cnt is read by the testbench for its closing summary
`timescale 1ns/1ps

module aa_bridge_asserts
  import aa_pkg::*;
(
  input logic                 axis_clk,
  input logic                 axis_rst_n,
  input logic [aa_data_w-1:0] aa_as_tdata,
  input logic [aa_strb_w-1:0] aa_as_tstrb,
  input logic [1:0]           aa_as_tuser,
  input logic                 aa_as_tvalid,
  input logic                 as_aa_tready,
  input logic [aa_data_w-1:0] s_rdata,
  input logic                 s_rvalid,
  input logic                 s_rready
);

  int fail_cnt = 0;

  // --------------------
  // stream out
  // --------------------
  // a stalled beat keeps valid and every field until ready
  stream_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=>
      aa_as_tvalid && $stable(aa_as_tdata) && $stable(aa_as_tstrb) && $stable(aa_as_tuser))
    else begin
      fail_cnt++;
      $error("outgoing stream beat changed while stalled");
    end

  // --------------------
  // axi-lite read data
  // --------------------
  rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin
      fail_cnt++;
      $error("s_rvalid or s_rdata changed before s_rready");
    end

endmodule

bind aa_bridge aa_bridge_asserts aa_bridge_asserts_i (.*);

//--- tests/aa_bridge_tb.sv
// testbench for aa_bridge with a remote peer model on the stream link
// the peer answers each read request with data derived from its address
// mailbox words are fully written before any readback relies on them
`timescale 1ns/1ps

module aa_bridge_tb
  import aa_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int rst_cycles      = 16;
  localparam int n_tests         = 6;
  localparam int test_cycles     = 300;
  localparam int watchdog_cycles = rst_cycles + n_tests * test_cycles;
  localparam logic [14:0] reg_base    = 15'h2100;
  localparam logic [14:0] mbox_base   = 15'h2000;
  localparam logic [14:0] remote_addr = 15'h4010;
  // header bits 27:8 of the remote mailbox page
  localparam logic [19:0] rem_mbox_prefix = 20'h00020;

  logic        axis_clk, axis_rst_n;
  logic        s_awready, s_awvalid, s_wready, s_wvalid, s_arready, s_arvalid;
  logic        s_rvalid, s_rready;
  logic [14:0] s_awaddr, s_araddr;
  logic [31:0] s_wdata, s_rdata;
  logic [3:0]  s_wstrb;
  logic [31:0] as_aa_tdata, aa_as_tdata;
  logic [3:0]  as_aa_tstrb, aa_as_tstrb;
  logic [1:0]  as_aa_tuser, aa_as_tuser;
  logic        as_aa_tvalid, aa_as_tready, aa_as_tvalid, as_aa_tready;
  logic        cc_aa_enable, mb_irq;

  integer      seed = 32'h91554df2;
  int          errors = 0;
  aa_beat_t    out_q[$];
  logic [31:0] mbox_model [8];
  logic        cpl_due = 1'b0;
  logic [27:0] cpl_addr;

  aa_bridge aa_bridge_i (.*);

  initial begin
    axis_clk = 1'b0;
    forever #(clk_period / 2) axis_clk = ~axis_clk;
  end

  // --------------------
  // remote peer
  // --------------------
  // random back-pressure, ready about three cycles in four
  // drawn on the rising edge and applied on the falling edge
  initial begin
    logic ready_nxt;
    as_aa_tready = 1'b0;
    @(posedge axis_rst_n);
    forever begin
      @(posedge axis_clk);
      ready_nxt = (($random(seed) & 3) != 0);
      @(negedge axis_clk);
      as_aa_tready = ready_nxt;
    end
  end

  // every transferred beat goes to out_q
  always @(posedge axis_clk) begin
    if (axis_rst_n && aa_as_tvalid && as_aa_tready) begin
      out_q.push_back(aa_beat_t'({aa_as_tdata, aa_as_tstrb, aa_as_tuser}));
      if (aa_as_tuser == cyc_read_req) begin
        cpl_addr = aa_as_tdata[27:0];
        cpl_due  = 1'b1;
      end
    end
  end

  initial begin
    forever begin
      @(negedge axis_clk);
      if (cpl_due) begin
        cpl_due = 1'b0;
        send_beat(peer_cpl_data(cpl_addr), 4'hf, cyc_read_cpl);
      end
    end
  end

  function automatic logic [31:0] peer_cpl_data(input logic [27:0] addr);
    return 32'hc0de0000 ^ {4'h0, addr};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic send_beat(input logic [31:0] data, input logic [3:0] strb, input aa_cyc_e user);
    @(negedge axis_clk);
    as_aa_tdata  = data;
    as_aa_tstrb  = strb;
    as_aa_tuser  = user;
    as_aa_tvalid = 1'b1;
    do @(posedge axis_clk); while (!aa_as_tready);
    @(negedge axis_clk);
    as_aa_tvalid = 1'b0;
  endtask

  task automatic axi_write(input logic [14:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge axis_clk);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    do @(posedge axis_clk); while (!(s_awready && s_wready));
    @(negedge axis_clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
  endtask

  // rready stays low for the first rvalid cycle so the hold is exercised
  task automatic axi_read(input logic [14:0] addr, output logic [31:0] data);
    @(negedge axis_clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    do @(posedge axis_clk); while (!s_arready);
    @(negedge axis_clk);
    s_arvalid = 1'b0;
    do @(posedge axis_clk); while (!s_rvalid);
    data = s_rdata;
    @(negedge axis_clk);
    s_rready = 1'b1;
    @(negedge axis_clk);
    s_rready = 1'b0;
  endtask

  task automatic check_beat(input string name, input logic [31:0] data, input logic [3:0] strb,
                            input aa_cyc_e user);
    aa_beat_t b;
    while (out_q.size() == 0) @(negedge axis_clk);
    b = out_q.pop_front();
    check_value({name, " tuser"}, user, b.tuser);
    check_value({name, " tstrb"}, strb, b.tstrb);
    check_value({name, " tdata"}, data, b.tdata);
  endtask

  // local mailbox write, its two forwarded beats, then readback
  task automatic local_mbox_write(input string name, input int idx, input logic [31:0] data,
                                  input logic [3:0] strb);
    logic [14:0] addr;
    logic [31:0] got;
    addr = mbox_base + 15'(idx * 4);
    axi_write(addr, data, strb);
    mbox_model[idx] = merge_bytes(mbox_model[idx], data, strb);
    check_beat({name, " header"}, {strb, 28'(addr)}, strb, cyc_write);
    check_beat({name, " data"}, data, strb, cyc_write);
    axi_read(addr, got);
    check_value({name, " readback"}, mbox_model[idx], got);
  endtask

  // --------------------
  // tests
  // --------------------
  initial begin
    logic [31:0] got;
    logic [31:0] wdata;
    logic [3:0]  strb;
    int          idx;
    axis_rst_n   = 1'b0;
    s_awvalid    = 1'b0;
    s_wvalid     = 1'b0;
    s_arvalid    = 1'b0;
    s_rready     = 1'b0;
    s_awaddr     = '0;
    s_araddr     = '0;
    s_wdata      = '0;
    s_wstrb      = '0;
    as_aa_tdata  = '0;
    as_aa_tstrb  = '0;
    as_aa_tuser  = '0;
    as_aa_tvalid = 1'b0;
    cc_aa_enable = 1'b1;
    repeat (rst_cycles) @(posedge axis_clk);
    @(negedge axis_clk);
    axis_rst_n = 1'b1;

    // 1: intr_enable stays local
    axi_write(reg_base, 32'h1, 4'hf);
    axi_read(reg_base, got);
    check_value("t1 intr_enable", 32'h1, got);
    check_value("t1 beat count", 32'h0, out_q.size());

    // 2: mailbox writes are merged and forwarded
    local_mbox_write("t2 full", 2, $random(seed), 4'hf);
    local_mbox_write("t2 strobed", 2, $random(seed), 4'($random(seed)));
    local_mbox_write("t2 word5", 5, $random(seed), 4'hf);

    // 3: remote mailbox write raises mb_irq, local clear drops it
    wdata = $random(seed);
    strb  = 4'($random(seed)) | 4'h1;
    send_beat({strb, rem_mbox_prefix, 8'(5 * 4)}, 4'hf, cyc_write);
    send_beat(wdata, 4'hf, cyc_write);
    mbox_model[5] = merge_bytes(mbox_model[5], wdata, strb);
    repeat (2) @(negedge axis_clk);
    check_value("t3 mb_irq set", 32'h1, mb_irq);
    axi_read(mbox_base + 15'd20, got);
    check_value("t3 mailbox word", mbox_model[5], got);
    axi_write(reg_base + 15'd4, 32'h1, 4'hf);
    check_value("t3 mb_irq cleared", 32'h0, mb_irq);
    check_value("t3 beat count", 32'h0, out_q.size());

    // 4: remote write and read through the peer
    wdata = $random(seed);
    strb  = 4'($random(seed));
    axi_write(remote_addr, wdata, strb);
    check_beat("t4 write header", {strb, 28'(remote_addr)}, strb, cyc_write);
    check_beat("t4 write data", wdata, strb, cyc_write);
    axi_read(remote_addr + 15'h10, got);
    check_beat("t4 read request", {4'h0, 28'(remote_addr + 15'h10)}, 4'hf, cyc_read_req);
    check_value("t4 read data", peer_cpl_data(28'(remote_addr + 15'h10)), got);

    // 5: remote reads of mailbox words under back-pressure
    for (int i = 0; i < 4; i++) begin
      idx = (i % 2 == 0) ? 2 : 5;
      send_beat({4'h0, rem_mbox_prefix, 8'(idx * 4)}, 4'hf, cyc_read_req);
      check_beat("t5 completion", mbox_model[idx], 4'hf, cyc_read_cpl);
    end

    // 6: no ready while the bridge is disabled
    cc_aa_enable = 1'b0;
    fork
      local_mbox_write("t6 gated", 7, $random(seed), 4'hf);
      begin
        repeat (50) begin
          @(negedge axis_clk);
          check_value("t6 ready while disabled", 32'h0, {s_awready, s_wready, s_arready});
        end
        cc_aa_enable = 1'b1;
      end
    join

    repeat (4) @(negedge axis_clk);
    $display("checks failed: %0d, assertions failed: %0d", errors,
             aa_bridge_i.aa_bridge_asserts_i.fail_cnt);
    if (errors == 0 && aa_bridge_i.aa_bridge_asserts_i.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- vlog.f
common/aa_pkg.sv
aa_regfile/aa_regfile.sv
ls_bridge/ls_bridge.sv
ss_bridge/ss_bridge.sv
rtl/aa_stream_tx.sv
rtl/aa_bridge.sv
tests/aa_bridge_asserts.sv
tests/aa_bridge_tb.sv
